//--- hw/cache_pkg.sv
package cache_pkg;

	// ----------------------------------------------------------
	// address split
	// ----------------------------------------------------------
	localparam int word_addr_bits = 16;                    // word addressed core space
	localparam int block_bits     = 2;                     // 4 words per block
	localparam int line_count     = 8;
	localparam int line_bits      = 3;                     // log2 of line_count
	localparam int tag_bits       = word_addr_bits - block_bits;
	localparam int ram_addr_bits  = line_bits + block_bits; // {line, word}
	localparam int wb_adr_bits    = 4;                     // byte offsets 0x0 to 0xC

	typedef logic [31:0]               word_t;
	typedef logic [word_addr_bits-1:0] word_addr_t;
	typedef logic [tag_bits-1:0]       tag_t;
	typedef logic [line_bits-1:0]      line_idx_t;

	// ----------------------------------------------------------
	// bundles between blocks
	// ----------------------------------------------------------
	typedef struct packed {
		logic       req;    // held until done
		logic       rw;     // 1 = write
		word_addr_t addr;
		word_t      wdata;
	} core_req_t;

	typedef struct packed {
		logic       req;
		logic       rw;     // 1 = writeback, 0 = fill
		word_addr_t addr;   // block aligned
	} mem_cmd_t;

	typedef struct packed {
		logic hit;
		logic miss;
		logic writeback;
	} cache_event_t;

	typedef enum logic [2:0] {
		s_idle,
		s_lookup,
		s_rd_wait,
		s_wb_cmd,
		s_wb_data,
		s_fill_cmd,
		s_fill_data,
		s_done
	} ctrl_state_e;

	// wishbone register map
	typedef enum logic [wb_adr_bits-1:0] {
		reg_ctrl   = 4'h0,
		reg_hits   = 4'h4,
		reg_misses = 4'h8,
		reg_wbacks = 4'hC
	} reg_addr_e;

endpackage

//--- hw/tag_cam.sv
module tag_cam (
	input  logic                 clock_i,
	input  logic                 rst_i,
	input  cache_pkg::tag_t      tag_i,          // lookup and install tag
	input  logic                 wren_i,         // install tag at line_i
	input  cache_pkg::line_idx_t line_i,
	input  logic                 set_dirty_i,
	input  logic                 clr_dirty_i,
	input  logic                 advance_i,      // bump fifo pointer
	output logic                 hit_o,
	output cache_pkg::line_idx_t hit_line_o,
	output cache_pkg::line_idx_t victim_o,
	output cache_pkg::tag_t      victim_tag_o,
	output logic                 victim_valid_o,
	output logic                 victim_dirty_o
);
	import cache_pkg::*;

	tag_t                  tags_q [line_count];  // tag payload
	logic [line_count-1:0] valid_q;
	logic [line_count-1:0] dirty_q;
	line_idx_t             ptr_q;                // oldest line

	// parallel compare over all valid entries
	always_comb begin
		hit_o      = 1'b0;
		hit_line_o = '0;
		for (int i = 0; i < line_count; i++) begin
			if (valid_q[i] && (tags_q[i] == tag_i)) begin
				hit_o      = 1'b1;
				hit_line_o = line_idx_t'(i);
			end
		end
	end

	assign victim_o       = ptr_q;
	assign victim_tag_o   = tags_q[ptr_q];
	assign victim_valid_o = valid_q[ptr_q];
	assign victim_dirty_o = dirty_q[ptr_q];

	always_ff @(posedge clock_i) begin
		if (wren_i)
			tags_q[line_i] <= tag_i;
	end

	// ----------------------------------------------------------
	// valid, dirty and fifo pointer
	// ----------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			valid_q <= '0;                     // cold cache
			dirty_q <= '0;
			ptr_q   <= '0;
		end else begin
			if (wren_i) begin
				valid_q[line_i] <= 1'b1;
				dirty_q[line_i] <= 1'b0;           // fresh fill is clean
			end else if (set_dirty_i) begin
				dirty_q[line_i] <= 1'b1;
			end else if (clr_dirty_i) begin
				dirty_q[line_i] <= 1'b0;
			end
			if (advance_i)
				ptr_q <= ptr_q + 1'b1;             // wraps at line_count
		end
	end

endmodule

//--- hw/cache_data_mem.sv
module cache_data_mem (
	input  logic                                clock_i,
	input  logic [cache_pkg::ram_addr_bits-1:0] addr_i,   // {line, word}
	input  logic                                we_i,
	input  cache_pkg::word_t                    wdata_i,
	output cache_pkg::word_t                    rdata_o   // one cycle after addr_i
);
	import cache_pkg::*;

	localparam int depth = line_count << block_bits;

	word_t mem_q [depth];

	// read returns old contents on a same-cycle write
	always_ff @(posedge clock_i) begin
		if (we_i)
			mem_q[addr_i] <= wdata_i;
		rdata_o <= mem_q[addr_i];
	end

endmodule

//--- hw/cache_controller.sv
module cache_controller (
	input  logic                                clock_i,
	input  logic                                rst_i,
	input  logic                                enable_i,
	// core side
	input  cache_pkg::core_req_t                core_i,
	output logic                                done_o,          // one cycle pulse
	output logic                                hit_o,           // original lookup result
	output cache_pkg::word_t                    rdata_o,
	// tag cam
	output cache_pkg::tag_t                     cam_tag_o,
	output logic                                cam_wren_o,
	output cache_pkg::line_idx_t                cam_line_o,
	output logic                                cam_set_dirty_o,
	output logic                                cam_clr_dirty_o,
	output logic                                cam_advance_o,
	input  logic                                cam_hit_i,
	input  cache_pkg::line_idx_t                cam_hit_line_i,
	input  cache_pkg::line_idx_t                cam_victim_i,
	input  cache_pkg::tag_t                     cam_victim_tag_i,
	input  logic                                cam_victim_valid_i,
	input  logic                                cam_victim_dirty_i,
	// data ram
	output logic [cache_pkg::ram_addr_bits-1:0] ram_addr_o,
	output logic                                ram_we_o,
	output cache_pkg::word_t                    ram_wdata_o,
	input  cache_pkg::word_t                    ram_rdata_i,
	// external memory
	output cache_pkg::mem_cmd_t                 mem_cmd_o,
	input  logic                                mem_ready_i,
	output logic                                mem_write_o,
	input  logic                                mem_ready_write_i,
	output cache_pkg::word_t                    mem_wdata_o,
	output logic                                mem_read_o,
	input  logic                                mem_ready_read_i,
	input  cache_pkg::word_t                    mem_rdata_i,
	// perf events
	output cache_pkg::cache_event_t             event_o
);
	import cache_pkg::*;

	ctrl_state_e           state_q, state_d;
	logic [block_bits-1:0] wcnt_q;         // word within block for wb and fill
	logic                  rd_valid_q;     // ram output matches wcnt_q
	logic                  first_q;        // first lookup of this request
	logic                  hit_q;
	word_t                 rdata_q;

	tag_t                  req_tag;
	logic [block_bits-1:0] req_word;
	logic                  wb_xfer, fill_xfer;
	logic                  wb_last, fill_last;
	logic                  in_lookup;

	assign req_tag   = core_i.addr[word_addr_bits-1:block_bits];
	assign req_word  = core_i.addr[block_bits-1:0];
	assign in_lookup = (state_q == s_lookup);

	assign wb_xfer   = mem_write_o && mem_ready_write_i;
	assign fill_xfer = (state_q == s_fill_data) && mem_ready_read_i;
	assign wb_last   = wb_xfer && (wcnt_q == '1);
	assign fill_last = fill_xfer && (wcnt_q == '1);

	// ----------------------------------------------------------
	// next state
	// ----------------------------------------------------------
	always_comb begin
		state_d = state_q;
		case (state_q)
			s_idle:      if (enable_i && core_i.req) state_d = s_lookup;
			s_lookup: begin
				if (cam_hit_i)
					state_d = s_rd_wait;
				else if (cam_victim_valid_i && cam_victim_dirty_i)
					state_d = s_wb_cmd;             // evict dirty victim first
				else
					state_d = s_fill_cmd;
			end
			s_rd_wait:   state_d = s_done;
			s_wb_cmd:    if (mem_ready_i) state_d = s_wb_data;
			s_wb_data:   if (wb_last) state_d = s_fill_cmd;
			s_fill_cmd:  if (mem_ready_i) state_d = s_fill_data;
			s_fill_data: if (fill_last) state_d = s_lookup;  // replay as hit
			s_done:      state_d = s_idle;
			default:     state_d = s_idle;
		endcase
	end

	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			state_q    <= s_idle;
			wcnt_q     <= '0;
			rd_valid_q <= 1'b0;
			first_q    <= 1'b0;
			hit_q      <= 1'b0;
		end else begin
			state_q <= state_d;
			case (state_q)
				s_idle: first_q <= 1'b1;
				s_lookup: begin
					first_q <= 1'b0;
					wcnt_q  <= '0;
					if (first_q)
						hit_q <= cam_hit_i;         // keep original outcome
				end
				s_wb_cmd: rd_valid_q <= 1'b1;   // word 0 addressed here
				s_wb_data: begin
					rd_valid_q <= !wb_xfer;         // new word lands a cycle later
					if (wb_xfer)
						wcnt_q <= wcnt_q + 1'b1;
				end
				s_fill_data: if (fill_xfer) wcnt_q <= wcnt_q + 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clock_i) begin
		if (state_q == s_rd_wait)
			rdata_q <= ram_rdata_i;             // capture hit data
	end

	assign done_o  = (state_q == s_done);
	assign hit_o   = hit_q;
	assign rdata_o = rdata_q;

	// ----------------------------------------------------------
	// cam and ram control
	// ----------------------------------------------------------
	assign cam_tag_o       = req_tag;
	assign cam_line_o      = in_lookup ? cam_hit_line_i : cam_victim_i;
	assign cam_wren_o      = fill_last;        // install after last word
	assign cam_advance_o   = fill_last;
	assign cam_set_dirty_o = in_lookup && cam_hit_i && core_i.rw;
	assign cam_clr_dirty_o = wb_last;

	always_comb begin
		ram_addr_o  = {cam_victim_i, wcnt_q};   // wb and fill walk the victim
		ram_we_o    = 1'b0;
		ram_wdata_o = mem_rdata_i;
		if (in_lookup) begin
			ram_addr_o  = {cam_hit_line_i, req_word};
			ram_we_o    = cam_hit_i && core_i.rw;
			ram_wdata_o = core_i.wdata;
		end else if (state_q == s_fill_data) begin
			ram_we_o = mem_ready_read_i;
		end
	end

	// ----------------------------------------------------------
	// memory command and data buffer
	// ----------------------------------------------------------
	always_comb begin
		mem_cmd_o.req  = (state_q == s_wb_cmd) || (state_q == s_fill_cmd);
		mem_cmd_o.rw   = (state_q == s_wb_cmd);
		mem_cmd_o.addr = (state_q == s_wb_cmd) ?
			{cam_victim_tag_i, {block_bits{1'b0}}} :
			{req_tag, {block_bits{1'b0}}};
	end

	assign mem_write_o = (state_q == s_wb_data) && rd_valid_q;
	assign mem_wdata_o = ram_rdata_i;
	assign mem_read_o  = fill_xfer;            // ack for the taken word

	// events once per request
	assign event_o.hit       = in_lookup && first_q && cam_hit_i;
	assign event_o.miss      = in_lookup && first_q && !cam_hit_i;
	assign event_o.writeback = in_lookup && !cam_hit_i
		&& cam_victim_valid_i && cam_victim_dirty_i;

endmodule

//--- hw/perf_counters.sv
module perf_counters (
	input  logic                              clock_i,
	input  logic                              rst_i,
	// wishbone classic slave
	input  logic                              wb_cyc_i,
	input  logic                              wb_stb_i,
	input  logic                              wb_we_i,
	input  logic [cache_pkg::wb_adr_bits-1:0] wb_adr_i,
	input  cache_pkg::word_t                  wb_dat_i,
	output cache_pkg::word_t                  wb_dat_o,
	output logic                              wb_ack_o,
	// controller side
	input  cache_pkg::cache_event_t           event_i,
	output logic                              enable_o
);
	import cache_pkg::*;

	logic       ack_q;
	logic       access;       // first cycle of a bus cycle
	logic       wr_ctrl;
	logic       clear;
	logic [2:0] ev_vec;       // hit, miss, wb in counter order
	word_t      cnt_q [3];
	word_t      dat_q;
	logic       enable_q;
	reg_addr_e  adr;

	assign adr     = reg_addr_e'(wb_adr_i);
	assign access  = wb_cyc_i && wb_stb_i && !ack_q;  // ack then a dead cycle
	assign wr_ctrl = access && wb_we_i && (adr == reg_ctrl);
	assign clear   = wr_ctrl && wb_dat_i[1];          // self clearing strobe
	assign ev_vec  = {event_i.writeback, event_i.miss, event_i.hit};

	// ----------------------------------------------------------
	// bus handshake and control register
	// ----------------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (rst_i) begin
			ack_q    <= 1'b0;
			enable_q <= 1'b0;       // cache parked until software enables
		end else begin
			ack_q <= access;
			if (wr_ctrl)
				enable_q <= wb_dat_i[0];
		end
	end

	// read data registered with the ack
	always_ff @(posedge clock_i) begin
		if (access) begin
			case (adr)
				reg_ctrl:   dat_q <= {31'b0, enable_q};
				reg_hits:   dat_q <= cnt_q[0];
				reg_misses: dat_q <= cnt_q[1];
				reg_wbacks: dat_q <= cnt_q[2];
				default:    dat_q <= '0;
			endcase
		end
	end

	// ----------------------------------------------------------
	// event counters
	// ----------------------------------------------------------
	always_ff @(posedge clock_i) begin
		for (int i = 0; i < 3; i++) begin
			if (rst_i || clear)
				cnt_q[i] <= '0;
			else if (ev_vec[i])
				cnt_q[i] <= cnt_q[i] + 1'b1;
		end
	end

	assign wb_ack_o = ack_q;
	assign wb_dat_o = dat_q;
	assign enable_o = enable_q;

endmodule

//--- hw/cache_fa_top.sv
module cache_fa_top (
	input  logic                              clock_i,
	input  logic                              rst_i,
	// core
	input  cache_pkg::core_req_t              core_i,
	output logic                              done_o,
	output logic                              hit_o,
	output cache_pkg::word_t                  rdata_o,
	// external memory
	output cache_pkg::mem_cmd_t               mem_cmd_o,
	input  logic                              mem_ready_i,
	output logic                              mem_write_o,
	input  logic                              mem_ready_write_i,
	output cache_pkg::word_t                  mem_wdata_o,
	output logic                              mem_read_o,
	input  logic                              mem_ready_read_i,
	input  cache_pkg::word_t                  mem_rdata_i,
	// wishbone
	input  logic                              wb_cyc_i,
	input  logic                              wb_stb_i,
	input  logic                              wb_we_i,
	input  logic [cache_pkg::wb_adr_bits-1:0] wb_adr_i,
	input  cache_pkg::word_t                  wb_dat_i,
	output cache_pkg::word_t                  wb_dat_o,
	output logic                              wb_ack_o
);
	import cache_pkg::*;

	// ----------------------------------------------------------
	// internal nets
	// ----------------------------------------------------------
	tag_t                     cam_tag, victim_tag;
	line_idx_t                cam_line, hit_line, victim;
	logic                     cam_wren, set_dirty, clr_dirty, advance;
	logic                     cam_hit, victim_valid, victim_dirty;
	logic [ram_addr_bits-1:0] ram_addr;
	logic                     ram_we;
	word_t                    ram_wdata, ram_rdata;
	cache_event_t             events;
	logic                     enable;

	cache_controller u_ctrl (
		.clock_i            (clock_i),
		.rst_i              (rst_i),
		.enable_i           (enable),
		.core_i             (core_i),
		.done_o             (done_o),
		.hit_o              (hit_o),
		.rdata_o            (rdata_o),
		.cam_tag_o          (cam_tag),
		.cam_wren_o         (cam_wren),
		.cam_line_o         (cam_line),
		.cam_set_dirty_o    (set_dirty),
		.cam_clr_dirty_o    (clr_dirty),
		.cam_advance_o      (advance),
		.cam_hit_i          (cam_hit),
		.cam_hit_line_i     (hit_line),
		.cam_victim_i       (victim),
		.cam_victim_tag_i   (victim_tag),
		.cam_victim_valid_i (victim_valid),
		.cam_victim_dirty_i (victim_dirty),
		.ram_addr_o         (ram_addr),
		.ram_we_o           (ram_we),
		.ram_wdata_o        (ram_wdata),
		.ram_rdata_i        (ram_rdata),
		.mem_cmd_o          (mem_cmd_o),
		.mem_ready_i        (mem_ready_i),
		.mem_write_o        (mem_write_o),
		.mem_ready_write_i  (mem_ready_write_i),
		.mem_wdata_o        (mem_wdata_o),
		.mem_read_o         (mem_read_o),
		.mem_ready_read_i   (mem_ready_read_i),
		.mem_rdata_i        (mem_rdata_i),
		.event_o            (events)
	);

	tag_cam u_cam (
		.clock_i        (clock_i),
		.rst_i          (rst_i),
		.tag_i          (cam_tag),
		.wren_i         (cam_wren),
		.line_i         (cam_line),
		.set_dirty_i    (set_dirty),
		.clr_dirty_i    (clr_dirty),
		.advance_i      (advance),
		.hit_o          (cam_hit),
		.hit_line_o     (hit_line),
		.victim_o       (victim),
		.victim_tag_o   (victim_tag),
		.victim_valid_o (victim_valid),
		.victim_dirty_o (victim_dirty)
	);

	cache_data_mem u_ram (
		.clock_i (clock_i),
		.addr_i  (ram_addr),
		.we_i    (ram_we),
		.wdata_i (ram_wdata),
		.rdata_o (ram_rdata)
	);

	perf_counters u_perf (
		.clock_i  (clock_i),
		.rst_i    (rst_i),
		.wb_cyc_i (wb_cyc_i),
		.wb_stb_i (wb_stb_i),
		.wb_we_i  (wb_we_i),
		.wb_adr_i (wb_adr_i),
		.wb_dat_i (wb_dat_i),
		.wb_dat_o (wb_dat_o),
		.wb_ack_o (wb_ack_o),
		.event_i  (events),
		.enable_o (enable)
	);

endmodule

//--- tb/backing_mem.sv
module backing_mem (
	input  logic                clock_i,
	input  cache_pkg::mem_cmd_t cmd_i,
	output logic                ready_o,        // command taken this cycle
	input  logic                write_i,
	output logic                ready_write_o,
	input  cache_pkg::word_t    wdata_i,
	input  logic                read_i,         // ack for each fill word taken
	output logic                ready_read_o,
	output cache_pkg::word_t    rdata_o
);
	timeunit 1ns;
	timeprecision 1ps;
	import cache_pkg::*;

	word_t                 mem [1 << word_addr_bits];
	logic [31:0]           lcg_q;
	logic [31:0]           r;
	int                    delay;     // cycles left before taking a command or -1
	logic                  busy;      // block transfer running
	logic                  is_wb;
	word_addr_t            base;
	logic [block_bits-1:0] cnt;       // word within the block
	logic                  read_seen; // fill word acked in the cycle just ended

	function automatic logic [31:0] lcg_step();
		lcg_q = lcg_q * 32'd1664525 + 32'd1013904223;
		return lcg_q;
	endfunction

	initial begin
		for (int a = 0; a < (1 << word_addr_bits); a++)
			mem[a] = a * 32'h9E37 + 1;
		lcg_q         = 32'd1;        // seed
		delay         = -1;
		busy          = 1'b0;
		is_wb         = 1'b0;
		base          = '0;
		cnt           = '0;
		read_seen     = 1'b0;
		ready_o       = 1'b0;
		ready_write_o = 1'b0;
		ready_read_o  = 1'b0;
		rdata_o       = '0;
	end

	// ack sampled at the rising edge where the word is taken
	always @(posedge clock_i)
		read_seen = read_i;

	// ----------------------------------------------------------
	// everything moves on the falling edge so the dut sees it at the rising one
	// ----------------------------------------------------------
	always @(negedge clock_i) begin
		if (read_seen) begin
			cnt++;                                           // next fill word
			if (cnt == '0)
				busy = 1'b0;                                // last fill word
		end
		r             = lcg_step();
		ready_o       = 1'b0;
		ready_write_o = (r[31:30] != 2'b00);              // busy about 1 in 4 cycles
		ready_read_o  = busy && !is_wb && (r[29:28] != 2'b00);
		rdata_o       = mem[base + cnt];
		if (busy && is_wb && write_i && ready_write_o) begin
			mem[base + cnt] = wdata_i;                     // lands at the next rising edge
			cnt++;
			if (cnt == '0)
				busy = 1'b0;
		end
		// command accept after a random delay
		if (!busy && cmd_i.req === 1'b1) begin
			if (delay < 0)
				delay = r[27:26];
			if (delay == 0) begin
				ready_o = 1'b1;
				busy    = 1'b1;
				is_wb   = cmd_i.rw;
				base    = cmd_i.addr;
				cnt     = '0;
				delay   = -1;
			end else begin
				delay--;
			end
		end
	end

endmodule

//--- tb/cache_tb.sv
module cache_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import cache_pkg::*;

	localparam int request_count  = 228;
	localparam int timeout_cycles = request_count * 200;

	logic                   clock = 1'b0;
	logic                   rst;
	core_req_t              core;
	logic                   done, hit;
	word_t                  rdata;
	mem_cmd_t               mem_cmd;
	logic                   mem_ready, mem_write, mem_ready_write, mem_read, mem_ready_read;
	word_t                  mem_wdata, mem_rdata;
	logic                   wb_cyc, wb_stb, wb_we, wb_ack;
	logic [wb_adr_bits-1:0] wb_adr;
	word_t                  wb_dat_w, wb_dat_r;

	// shadow of the core view plus fifo tag store
	word_t                 shadow [1 << word_addr_bits];
	tag_t                  ref_tag [line_count];
	logic [line_count-1:0] ref_valid = '0;
	logic [line_count-1:0] ref_dirty = '0;
	line_idx_t             ref_ptr = '0;
	logic [31:0]           ref_hits = 0, ref_misses = 0, ref_wbacks = 0;

	word_t exp_data_q [$];    // one entry per outstanding request
	logic  exp_hit_q [$];
	logic  exp_read_q [$];

	int          data_errs = 0, hit_errs = 0, count_errs = 0, other_errs = 0;
	logic [31:0] rnd_state = 32'd1;

	cache_fa_top UUT (
		.clock_i (clock), .rst_i (rst),
		.core_i (core), .done_o (done), .hit_o (hit), .rdata_o (rdata),
		.mem_cmd_o (mem_cmd), .mem_ready_i (mem_ready),
		.mem_write_o (mem_write), .mem_ready_write_i (mem_ready_write),
		.mem_wdata_o (mem_wdata), .mem_read_o (mem_read),
		.mem_ready_read_i (mem_ready_read), .mem_rdata_i (mem_rdata),
		.wb_cyc_i (wb_cyc), .wb_stb_i (wb_stb), .wb_we_i (wb_we), .wb_adr_i (wb_adr),
		.wb_dat_i (wb_dat_w), .wb_dat_o (wb_dat_r), .wb_ack_o (wb_ack)
	);

	backing_mem u_mem (
		.clock_i (clock), .cmd_i (mem_cmd), .ready_o (mem_ready),
		.write_i (mem_write), .ready_write_o (mem_ready_write), .wdata_i (mem_wdata),
		.read_i (mem_read), .ready_read_o (mem_ready_read), .rdata_o (mem_rdata)
	);

	initial begin
		forever #10 clock = ~clock;
	end

	// ----------------------------------------------------------
	// reference model
	// ----------------------------------------------------------
	function automatic word_t backing_init(word_addr_t a);
		return 32'(a) * 32'h9E37 + 32'd1;
	endfunction

	function automatic logic [31:0] next_random();
		rnd_state = rnd_state * 32'd1664525 + 32'd1013904223;
		return rnd_state;
	endfunction

	// returns the predicted hit, updates tags, counts and shadow
	function automatic logic ref_access(input logic rw, input word_addr_t addr,
		input word_t wdata, output word_t exp_rdata);
		tag_t      t;
		logic      found;
		line_idx_t line;
		t     = addr[word_addr_bits-1:block_bits];
		found = 1'b0;
		line  = '0;
		for (int i = 0; i < line_count; i++) begin
			if (ref_valid[i] && ref_tag[i] == t) begin
				found = 1'b1;
				line  = line_idx_t'(i);
			end
		end
		if (found) begin
			ref_hits++;
		end else begin
			ref_misses++;
			if (ref_valid[ref_ptr] && ref_dirty[ref_ptr])
				ref_wbacks++;                          // dirty victim goes out first
			line            = ref_ptr;
			ref_tag[line]   = t;
			ref_valid[line] = 1'b1;
			ref_dirty[line] = 1'b0;
			ref_ptr++;
		end
		exp_rdata = shadow[addr];
		if (rw) begin
			shadow[addr]    = wdata;
			ref_dirty[line] = 1'b1;
		end
		return found;
	endfunction

	// ----------------------------------------------------------
	// compare tasks
	// ----------------------------------------------------------
	task automatic check_word(input string name, input word_t exp, input word_t got);
		if (got !== exp) begin
			data_errs++;
			$display("MISMATCH %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic check_hit(input string name, input logic exp, input logic got);
		if (got !== exp) begin
			hit_errs++;
			$display("MISMATCH %s: expected %h, got %h", name, exp, got);
		end
	endtask

	task automatic check_count(input string name, input logic [31:0] exp,
		input logic [31:0] got);
		if (got !== exp) begin
			count_errs++;
			$display("MISMATCH %s: expected %h, got %h", name, exp, got);
		end
	endtask

	// completion checker, oldest expectation first
	always @(negedge clock) begin : compare_done
		word_t exp_data;
		logic  exp_hit;
		logic  exp_read;
		if (!rst && done === 1'b1) begin
			if (exp_data_q.size() == 0) begin
				other_errs++;
				$display("done_o pulsed with no request outstanding");
			end else begin
				exp_data = exp_data_q.pop_front();
				exp_hit  = exp_hit_q.pop_front();
				exp_read = exp_read_q.pop_front();
				if (exp_read)
					check_word("rdata_o", exp_data, rdata);  // write returns stale data
				check_hit("hit_o", exp_hit, hit);
			end
		end
	end

	// ----------------------------------------------------------
	// core and wishbone drivers
	// ----------------------------------------------------------
	task automatic issue_req(input logic rw, input word_addr_t addr, input word_t wdata);
		word_t d;
		logic  h;
		h = ref_access(rw, addr, wdata, d);
		exp_data_q.push_back(d);
		exp_hit_q.push_back(h);
		exp_read_q.push_back(!rw);
		@(negedge clock);
		core.req   = 1'b1;
		core.rw    = rw;
		core.addr  = addr;
		core.wdata = wdata;
	endtask

	task automatic wait_done(output int cycles);
		cycles = 0;
		do begin
			@(negedge clock);
			cycles++;
		end while (done !== 1'b1);
		core.req = 1'b0;                            // dropped inside the done cycle
	endtask

	task automatic access(input logic rw, input word_addr_t addr, input word_t wdata);
		int   cycles;
		logic exp_hit;
		issue_req(rw, addr, wdata);
		exp_hit = exp_hit_q[$];
		wait_done(cycles);
		if (exp_hit)
			check_count("done_o latency", 32'd3, cycles);
	endtask

	task automatic bus_cycle(input logic we, input reg_addr_e adr, input word_t wdat,
		output word_t rdat);
		@(negedge clock);
		wb_cyc   = 1'b1;
		wb_stb   = 1'b1;
		wb_we    = we;
		wb_adr   = adr;
		wb_dat_w = wdat;
		do @(negedge clock); while (wb_ack !== 1'b1);
		rdat   = wb_dat_r;
		wb_cyc = 1'b0;
		wb_stb = 1'b0;
		wb_we  = 1'b0;
	endtask

	task automatic check_counters(input logic [31:0] hits, input logic [31:0] misses,
		input logic [31:0] wbacks);
		word_t rd;
		bus_cycle(1'b0, reg_hits, '0, rd);
		check_count("reg_hits", hits, rd);
		bus_cycle(1'b0, reg_misses, '0, rd);
		check_count("reg_misses", misses, rd);
		bus_cycle(1'b0, reg_wbacks, '0, rd);
		check_count("reg_wbacks", wbacks, rd);
	endtask

	// ----------------------------------------------------------
	// stimulus
	// ----------------------------------------------------------
	initial begin
		word_t       rd;
		logic [31:0] r;
		int          cycles;
		rst      = 1'b1;
		core     = '0;
		wb_cyc   = 1'b0;
		wb_stb   = 1'b0;
		wb_we    = 1'b0;
		wb_adr   = '0;
		wb_dat_w = '0;
		for (int a = 0; a < (1 << word_addr_bits); a++)
			shadow[a] = backing_init(word_addr_t'(a));
		repeat (3) @(posedge clock);
		@(negedge clock);
		rst = 1'b0;

		// parked request waits for enable
		issue_req(1'b0, 16'h0100, '0);
		repeat (20) begin
			@(negedge clock);
			if (done === 1'b1) begin
				other_errs++;
				$display("done_o pulsed while the cache was disabled");
			end
		end
		bus_cycle(1'b1, reg_ctrl, 32'h1, rd);
		wait_done(cycles);
		bus_cycle(1'b0, reg_ctrl, '0, rd);
		check_word("reg_ctrl", 32'h1, rd);

		// cold miss, then hits in the same block
		access(1'b0, 16'h0200, '0);
		access(1'b0, 16'h0200, '0);
		for (int w = 1; w < 4; w++)
			access(1'b0, word_addr_t'(16'h0200 + w), '0);

		// writes, read back, fifo eviction of the dirty block
		for (int w = 0; w < 4; w++)
			access(1'b1, word_addr_t'(16'h0300 + w), 32'hA5A5_0000 + w);
		for (int w = 0; w < 4; w++)
			access(1'b0, word_addr_t'(16'h0300 + w), '0);
		for (int b = 0; b < 9; b++)
			access(1'b0, word_addr_t'(16'h1000 + 4 * b), '0);  // 9 new blocks
		check_word("backing word 0300", 32'hA5A5_0000, u_mem.mem[16'h0300]);
		for (int w = 0; w < 4; w++)
			access(1'b0, word_addr_t'(16'h0300 + w), '0);
		access(1'b0, 16'h0100, '0);             // oldest block long gone

		// random mix over 16 blocks
		for (int n = 0; n < 200; n++) begin
			r = next_random();
			access(r[25], 16'h4000 + {r[31:28], r[27:26]}, next_random());
		end

		// counters, then clear with enable kept
		check_counters(ref_hits, ref_misses, ref_wbacks);
		bus_cycle(1'b1, reg_ctrl, 32'h3, rd);
		check_counters('0, '0, '0);

		if (exp_data_q.size() != 0) begin
			other_errs++;
			$display("%0d requests never completed", exp_data_q.size());
		end
		$display("errors: data %0d, hit %0d, count %0d, other %0d",
			data_errs, hit_errs, count_errs, other_errs);
		if (data_errs + hit_errs + count_errs + other_errs == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// watchdog sized from the request count
	initial begin
		repeat (timeout_cycles) @(posedge clock);
		$display("watchdog expired after %0d cycles, the run did not finish", timeout_cycles);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

//--- project.f
hw/cache_pkg.sv
hw/tag_cam.sv
hw/cache_data_mem.sv
hw/cache_controller.sv
hw/perf_counters.sv
hw/cache_fa_top.sv
tb/backing_mem.sv
tb/cache_tb.sv
